//--- exec_pkg.sv
// Shared widths, opcode and funct codes for the RV32I execute stage.
// Only the RV32I base integer subset is covered: no fence, system or
// M-extension encodings. Load size codes follow the data bus of the
// surrounding core (byte 0, half 1, word 3).

package exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [3:0]      strb_t;
    typedef logic [1:0]      load_size_t;

    // ----------------------------------------
    // major opcodes
    // ----------------------------------------
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;

    // ----------------------------------------
    // funct3 / funct7
    // ----------------------------------------
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;    // sub, sra, srai

    localparam load_size_t SIZE_BYTE = 2'd0;
    localparam load_size_t SIZE_HALF = 2'd1;
    localparam load_size_t SIZE_WORD = 2'd3;

    localparam xlen_t INST_BYTES = 32'd4;        // link offset, no compressed isa

endpackage

//--- exec_operand_if.sv
// Latched instruction as seen by the execute units.
// rs1_val and rs2_val are already resolved against the forwarding paths.
// Plain levels, valid for the whole cycle; there is no handshake.

`timescale 1ns/1ps

interface exec_operand_if;

    logic              valid;
    exec_pkg::xlen_t   pc;
    exec_pkg::opcode_t opcode;
    exec_pkg::funct3_t funct3;
    exec_pkg::funct7_t funct7;
    exec_pkg::xlen_t   imm;
    exec_pkg::xlen_t   rs1_val;
    exec_pkg::xlen_t   rs2_val;

    modport issue (
        output valid, pc, opcode, funct3, funct7, imm, rs1_val, rs2_val
    );

    modport unit (
        input valid, pc, opcode, funct3, funct7, imm, rs1_val, rs2_val
    );

endinterface

//--- exec_issue_reg.sv
// Decode-to-execute pipeline latch with operand forwarding.
// Priority is reset, then stall (hold), then flush (bubble), then load.
// A bubble has every field zero, so opcode 0 keeps the units idle.
// Forwarding is combinational on the latched source indices; the memory
// stage result wins over writeback, and x0 always reads zero.

`timescale 1ns/1ps

module exec_issue_reg (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 stall,
    input  logic                 flush,

    input  exec_pkg::xlen_t      d_pc,
    input  logic                 d_valid,
    input  exec_pkg::opcode_t    d_opcode,
    input  exec_pkg::funct3_t    d_funct3,
    input  exec_pkg::funct7_t    d_funct7,
    input  exec_pkg::xlen_t      d_imm,
    input  exec_pkg::reg_idx_t   d_rd,
    input  exec_pkg::reg_idx_t   d_rs1,
    input  exec_pkg::xlen_t      d_rs1_val,
    input  exec_pkg::reg_idx_t   d_rs2,
    input  exec_pkg::xlen_t      d_rs2_val,

    input  logic                 fwd_m_valid,
    input  exec_pkg::reg_idx_t   fwd_m_rd,
    input  exec_pkg::xlen_t      fwd_m_rd_val,
    input  logic                 fwd_w_valid,
    input  exec_pkg::reg_idx_t   fwd_w_rd,
    input  exec_pkg::xlen_t      fwd_w_rd_val,

    output exec_pkg::reg_idx_t   a_rd,
    exec_operand_if.issue        op
);

    exec_pkg::reg_idx_t rs1_q, rs2_q;
    exec_pkg::xlen_t    rs1_val_q, rs2_val_q;
    logic               clear;

    assign clear = RST || (flush && !stall);

    // ----------------------------------------
    // latch
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (clear) begin
            op.valid  <= 1'b0;
            op.pc     <= '0;
            op.opcode <= '0;
            op.funct3 <= '0;
            op.funct7 <= '0;
            op.imm    <= '0;
            a_rd      <= '0;
            rs1_q     <= '0;
            rs1_val_q <= '0;
            rs2_q     <= '0;
            rs2_val_q <= '0;
        end else if (!stall) begin
            op.valid  <= d_valid;
            op.pc     <= d_pc;
            op.opcode <= d_opcode;
            op.funct3 <= d_funct3;
            op.funct7 <= d_funct7;
            op.imm    <= d_imm;
            a_rd      <= d_rd;
            rs1_q     <= d_rs1;
            rs1_val_q <= d_rs1_val;
            rs2_q     <= d_rs2;
            rs2_val_q <= d_rs2_val;
        end
    end

    // ----------------------------------------
    // forwarding
    // ----------------------------------------
    function automatic exec_pkg::xlen_t fwd_sel(
        input exec_pkg::reg_idx_t idx,
        input exec_pkg::xlen_t    reg_val,
        input logic               m_valid,
        input exec_pkg::reg_idx_t m_rd,
        input exec_pkg::xlen_t    m_val,
        input logic               w_valid,
        input exec_pkg::reg_idx_t w_rd,
        input exec_pkg::xlen_t    w_val
    );
        if (idx == '0)
            return '0;                      // x0 hardwired
        else if (m_valid && m_rd == idx)
            return m_val;                   // youngest result first
        else if (w_valid && w_rd == idx)
            return w_val;
        return reg_val;
    endfunction

    always_comb begin
        op.rs1_val = fwd_sel(rs1_q, rs1_val_q, fwd_m_valid, fwd_m_rd, fwd_m_rd_val,
                             fwd_w_valid, fwd_w_rd, fwd_w_rd_val);
        op.rs2_val = fwd_sel(rs2_q, rs2_val_q, fwd_m_valid, fwd_m_rd, fwd_m_rd_val,
                             fwd_w_valid, fwd_w_rd, fwd_w_rd_val);
    end

    // a flush that is not overridden by stall leaves a bubble behind
    a_flush_bubble: assert property (@(posedge CLK) disable iff (RST)
        (flush && !stall) |=> !op.valid)
        else $error("valid still set after flush");

endmodule

//--- exec_int_alu.sv
// Destination value for register, immediate, lui, auipc and link results.
// Shift amounts use the low five bits only. Encodings outside RV32I,
// including unknown funct7 values on register ops, give zero.
// The result follows the latched opcode, not the valid bit.

`timescale 1ns/1ps

module exec_int_alu (
    exec_operand_if.unit     op,
    output exec_pkg::xlen_t  rd_val
);

    exec_pkg::xlen_t imm_i;
    exec_pkg::xlen_t opb;
    logic [4:0]      shamt;
    logic            is_reg;
    logic            f7_base, f7_alt;
    logic            plain_ok;
    logic            lt_s, lt_u;

    assign imm_i    = {{20{op.imm[11]}}, op.imm[11:0]};
    assign is_reg   = op.opcode == exec_pkg::OP_REG;
    assign opb      = is_reg ? op.rs2_val : imm_i;     // second operand
    assign shamt    = opb[4:0];
    assign f7_base  = op.funct7 == exec_pkg::F7_BASE;
    assign f7_alt   = op.funct7 == exec_pkg::F7_ALT;
    assign plain_ok = !is_reg || f7_base;              // immediates ignore funct7
    assign lt_s     = $signed(op.rs1_val) < $signed(opb);
    assign lt_u     = op.rs1_val < opb;

    always_comb begin
        rd_val = '0;
        case (op.opcode)
            exec_pkg::OP_REG, exec_pkg::OP_IMM: begin
                case (op.funct3)
                    exec_pkg::F3_ADD_SUB: begin
                        if (is_reg && f7_alt)
                            rd_val = op.rs1_val - opb;     // sub
                        else if (plain_ok)
                            rd_val = op.rs1_val + opb;     // add, addi
                    end
                    exec_pkg::F3_SLL: begin
                        if (f7_base)
                            rd_val = op.rs1_val << shamt;
                    end
                    exec_pkg::F3_SLT: begin
                        if (plain_ok)
                            rd_val = exec_pkg::xlen_t'(lt_s);
                    end
                    exec_pkg::F3_SLTU: begin
                        if (plain_ok)
                            rd_val = exec_pkg::xlen_t'(lt_u);
                    end
                    exec_pkg::F3_XOR: begin
                        if (plain_ok)
                            rd_val = op.rs1_val ^ opb;
                    end
                    exec_pkg::F3_OR: begin
                        if (plain_ok)
                            rd_val = op.rs1_val | opb;
                    end
                    exec_pkg::F3_AND: begin
                        if (plain_ok)
                            rd_val = op.rs1_val & opb;
                    end
                    exec_pkg::F3_SRL_SRA: begin
                        if (f7_base)
                            rd_val = op.rs1_val >> shamt;
                        else if (f7_alt)
                            rd_val = $signed(op.rs1_val) >>> shamt;
                    end
                    default: rd_val = '0;
                endcase
            end
            exec_pkg::OP_LUI:   rd_val = {op.imm[31:12], 12'b0};
            exec_pkg::OP_AUIPC: rd_val = op.pc + {op.imm[31:12], 12'b0};
            exec_pkg::OP_JAL:   rd_val = op.pc + exec_pkg::INST_BYTES;     // link
            exec_pkg::OP_JALR: begin
                if (op.funct3 == 3'b000)
                    rd_val = op.pc + exec_pkg::INST_BYTES;
            end
            default: rd_val = '0;
        endcase
    end

endmodule

//--- exec_branch_unit.sv
// Jump decision and target for the six branches, jal and jalr.
// new_pc carries the branch target even when the branch is not taken.
// Branch and jal targets assume an aligned pc from fetch.

`timescale 1ns/1ps

module exec_branch_unit (
    exec_operand_if.unit     op,
    output logic             do_jmp,
    output exec_pkg::xlen_t  new_pc
);

    exec_pkg::xlen_t br_off, jal_off, jalr_sum;
    logic            eq, lt_s, lt_u;

    assign br_off   = {{19{op.imm[12]}}, op.imm[12:1], 1'b0};
    assign jal_off  = {{11{op.imm[20]}}, op.imm[20:1], 1'b0};
    assign jalr_sum = op.rs1_val + {{20{op.imm[11]}}, op.imm[11:0]};

    assign eq   = op.rs1_val == op.rs2_val;
    assign lt_s = $signed(op.rs1_val) < $signed(op.rs2_val);
    assign lt_u = op.rs1_val < op.rs2_val;

    always_comb begin
        do_jmp = 1'b0;
        new_pc = '0;
        case (op.opcode)
            exec_pkg::OP_BRANCH: begin
                new_pc = op.pc + br_off;
                case (op.funct3)
                    exec_pkg::F3_BEQ:  do_jmp = eq;
                    exec_pkg::F3_BNE:  do_jmp = !eq;
                    exec_pkg::F3_BLT:  do_jmp = lt_s;
                    exec_pkg::F3_BGE:  do_jmp = !lt_s;
                    exec_pkg::F3_BLTU: do_jmp = lt_u;
                    exec_pkg::F3_BGEU: do_jmp = !lt_u;
                    default:           new_pc = '0;     // not a branch
                endcase
            end
            exec_pkg::OP_JAL: begin
                do_jmp = 1'b1;
                new_pc = op.pc + jal_off;
            end
            exec_pkg::OP_JALR: begin
                if (op.funct3 == 3'b000) begin
                    do_jmp = 1'b1;
                    new_pc = {jalr_sum[31:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

    // catches a misaligned pc arriving from fetch on branch and jal
    always_comb begin
        a_jmp_align: assert (!do_jmp || !new_pc[0])
            else $error("jump target with bit 0 set");
    end

endmodule

//--- exec_mem_req.sv
// Load and store request fields for the data memory port.
// Address is rs1 plus the sign-extended 12-bit immediate.
// Store strobe and data are lane-shifted by the low address bits; no
// misalignment check is made here. Non-memory opcodes give all zeros.

`timescale 1ns/1ps

module exec_mem_req (
    exec_operand_if.unit          op,
    output logic                  load_rden,
    output exec_pkg::xlen_t       load_addr,
    output exec_pkg::load_size_t  load_size,
    output logic                  load_signed,
    output logic                  store_wren,
    output exec_pkg::xlen_t       store_addr,
    output exec_pkg::strb_t       store_strb,
    output exec_pkg::xlen_t       store_data
);

    exec_pkg::xlen_t addr;
    logic [4:0]      lane_bits;

    assign addr      = op.rs1_val + {{20{op.imm[11]}}, op.imm[11:0]};
    assign lane_bits = {addr[1:0], 3'b000};     // byte lane to bit offset

    // ----------------------------------------
    // load request
    // ----------------------------------------
    always_comb begin
        load_rden   = 1'b1;
        load_size   = exec_pkg::SIZE_BYTE;
        load_signed = 1'b1;
        case (op.funct3)
            exec_pkg::F3_B:  ;
            exec_pkg::F3_BU: load_signed = 1'b0;
            exec_pkg::F3_H:  load_size   = exec_pkg::SIZE_HALF;
            exec_pkg::F3_HU: begin
                load_size   = exec_pkg::SIZE_HALF;
                load_signed = 1'b0;
            end
            exec_pkg::F3_W:  load_size   = exec_pkg::SIZE_WORD;
            default:         load_rden   = 1'b0;
        endcase
        if (op.opcode != exec_pkg::OP_LOAD || !load_rden) begin
            load_rden   = 1'b0;
            load_size   = exec_pkg::SIZE_BYTE;
            load_signed = 1'b0;
        end
        load_addr = load_rden ? addr : '0;
    end

    // ----------------------------------------
    // store request
    // ----------------------------------------
    always_comb begin
        store_wren = op.opcode == exec_pkg::OP_STORE;
        store_strb = '0;
        store_data = '0;
        if (store_wren) begin
            case (op.funct3)
                exec_pkg::F3_B: begin
                    store_strb = 4'b0001 << addr[1:0];
                    store_data = op.rs2_val << lane_bits;
                end
                exec_pkg::F3_H: begin
                    store_strb = 4'b0011 << addr[1:0];
                    store_data = op.rs2_val << lane_bits;
                end
                exec_pkg::F3_W: begin
                    store_strb = 4'b1111;
                    store_data = op.rs2_val;     // whole word
                end
                default: store_wren = 1'b0;
            endcase
        end
        store_addr = store_wren ? addr : '0;
    end

    // the two request paths decode the opcode separately
    always_comb begin
        a_one_req: assert (!(load_rden && store_wren))
            else $error("load and store requested together");
    end

endmodule

//--- exec_stage.sv
// Execute stage of a five-stage RV32I pipeline.
// One cycle from the d_ inputs to the a_ outputs; forwarding inputs act
// in the same cycle. Jump and request outputs follow the latched opcode
// and are not gated by a_valid; a flush or reset zeroes the opcode.

`timescale 1ns/1ps

module exec_stage (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  stall,
    input  logic                  flush,

    input  exec_pkg::xlen_t       d_pc,
    input  logic                  d_valid,
    input  exec_pkg::opcode_t     d_opcode,
    input  exec_pkg::funct3_t     d_funct3,
    input  exec_pkg::funct7_t     d_funct7,
    input  exec_pkg::xlen_t       d_imm,
    input  exec_pkg::reg_idx_t    d_rd,
    input  exec_pkg::reg_idx_t    d_rs1,
    input  exec_pkg::xlen_t       d_rs1_val,
    input  exec_pkg::reg_idx_t    d_rs2,
    input  exec_pkg::xlen_t       d_rs2_val,

    input  logic                  fwd_m_valid,
    input  exec_pkg::reg_idx_t    fwd_m_rd,
    input  exec_pkg::xlen_t       fwd_m_rd_val,
    input  logic                  fwd_w_valid,
    input  exec_pkg::reg_idx_t    fwd_w_rd,
    input  exec_pkg::xlen_t       fwd_w_rd_val,

    output exec_pkg::xlen_t       a_pc,
    output logic                  a_valid,
    output logic                  a_do_jmp,
    output exec_pkg::xlen_t       a_new_pc,
    output exec_pkg::reg_idx_t    a_rd,
    output exec_pkg::xlen_t       a_rd_val,
    output logic                  a_load_rden,
    output exec_pkg::xlen_t       a_load_addr,
    output exec_pkg::load_size_t  a_load_size,
    output logic                  a_load_signed,
    output logic                  a_store_wren,
    output exec_pkg::xlen_t       a_store_addr,
    output exec_pkg::strb_t       a_store_strb,
    output exec_pkg::xlen_t       a_store_data
);

    exec_operand_if op_bus ();

    assign a_pc    = op_bus.pc;
    assign a_valid = op_bus.valid;

    exec_issue_reg u_issue (
        .CLK, .RST, .stall, .flush,
        .d_pc, .d_valid, .d_opcode, .d_funct3, .d_funct7, .d_imm,
        .d_rd, .d_rs1, .d_rs1_val, .d_rs2, .d_rs2_val,
        .fwd_m_valid, .fwd_m_rd, .fwd_m_rd_val,
        .fwd_w_valid, .fwd_w_rd, .fwd_w_rd_val,
        .a_rd,
        .op (op_bus.issue)
    );

    exec_int_alu u_alu (
        .op     (op_bus.unit),
        .rd_val (a_rd_val)
    );

    exec_branch_unit u_branch (
        .op     (op_bus.unit),
        .do_jmp (a_do_jmp),
        .new_pc (a_new_pc)
    );

    exec_mem_req u_mem (
        .op          (op_bus.unit),
        .load_rden   (a_load_rden),
        .load_addr   (a_load_addr),
        .load_size   (a_load_size),
        .load_signed (a_load_signed),
        .store_wren  (a_store_wren),
        .store_addr  (a_store_addr),
        .store_strb  (a_store_strb),
        .store_data  (a_store_data)
    );

endmodule

//--- tb_exec_ref.svh
// Reference model for the execute stage testbench, built from the ISA rules.
// Included inside the testbench module; uses its fwd_ signals by argument.
// LCG state starts at seed 10 and is shared by every random draw.

`ifndef TB_EXEC_REF_SVH
`define TB_EXEC_REF_SVH

logic [31:0] lcg_state = 32'd10;

function automatic logic [31:0] rand32();
    logic [31:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi = {16'b0, lcg_state[31:16]};
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi[15:0], lcg_state[31:16]};
endfunction

function automatic logic [31:0] sext12(input logic [31:0] imm);
    return {{20{imm[11]}}, imm[11:0]};
endfunction

// source value after x0, memory stage, then writeback priority
function automatic logic [31:0] forwarded_operand(input logic [4:0] idx,
        input logic [31:0] rv,
        input logic mv, input logic [4:0] mrd, input logic [31:0] mval,
        input logic wv, input logic [4:0] wrd, input logic [31:0] wval);
    if (idx == 5'd0)
        return 32'd0;
    if (mv && mrd == idx)
        return mval;
    if (wv && wrd == idx)
        return wval;
    return rv;
endfunction

function automatic logic [31:0] dest_value(input logic [6:0] opc, input logic [2:0] f3,
        input logic [6:0] f7, input logic [31:0] pc, imm, a, b);
    logic [31:0] y;
    logic        alt;
    y   = (opc == exec_pkg::OP_REG) ? b : sext12(imm);
    alt = f7 == exec_pkg::F7_ALT;
    if (opc == exec_pkg::OP_REG || opc == exec_pkg::OP_IMM) begin
        case (f3)
            3'd0: return (alt && opc == exec_pkg::OP_REG) ? a - y : a + y;
            3'd1: return a << y[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(y)};
            3'd3: return {31'b0, a < y};
            3'd4: return a ^ y;
            3'd5: return alt ? 32'($signed(a) >>> y[4:0]) : a >> y[4:0];
            3'd6: return a | y;
            default: return a & y;
        endcase
    end
    if (opc == exec_pkg::OP_LUI)
        return {imm[31:12], 12'b0};
    if (opc == exec_pkg::OP_AUIPC)
        return pc + {imm[31:12], 12'b0};
    if (opc == exec_pkg::OP_JAL || opc == exec_pkg::OP_JALR)
        return pc + 32'd4;                  // link, jalr only driven with funct3 0
    return 32'd0;
endfunction

// {do_jmp, new_pc}
function automatic logic [32:0] jump_outcome(input logic [6:0] opc, input logic [2:0] f3,
        input logic [31:0] pc, imm, a, b);
    logic        t;
    logic [31:0] s;
    if (opc == exec_pkg::OP_JAL)
        return {1'b1, pc + {{11{imm[20]}}, imm[20:1], 1'b0}};
    if (opc == exec_pkg::OP_JALR) begin
        s = a + sext12(imm);
        return {1'b1, s[31:1], 1'b0};
    end
    if (opc != exec_pkg::OP_BRANCH)
        return 33'd0;
    case (f3)
        3'd0: t = a == b;
        3'd1: t = a != b;
        3'd4: t = $signed(a) < $signed(b);
        3'd5: t = $signed(a) >= $signed(b);
        3'd6: t = a < b;
        default: t = a >= b;
    endcase
    return {t, pc + {{19{imm[12]}}, imm[12:1], 1'b0}};
endfunction

// {rden, addr, size, signed}
function automatic logic [35:0] load_request(input logic [6:0] opc, input logic [2:0] f3,
        input logic [31:0] a, imm);
    if (opc != exec_pkg::OP_LOAD || f3 == 3'd3 || f3 > 3'd5)
        return 36'd0;
    return {1'b1, a + sext12(imm), (f3[1:0] == 2'd2) ? 2'd3 : f3[1:0], !f3[2]};
endfunction

// {wren, addr, strb, data}
function automatic logic [68:0] store_request(input logic [6:0] opc, input logic [2:0] f3,
        input logic [31:0] a, b, imm);
    logic [31:0] ad;
    ad = a + sext12(imm);
    if (opc != exec_pkg::OP_STORE || f3 > 3'd2)
        return 69'd0;
    if (f3 == 3'd2)
        return {1'b1, ad, 4'b1111, b};
    return {1'b1, ad, 4'((f3 == 3'd0 ? 4'b0001 : 4'b0011) << ad[1:0]),
            b << {ad[1:0], 3'b000}};
endfunction

`endif

//--- tb_exec_stage.sv
// Testbench for the execute stage: random instruction stream with stall,
// flush and forwarding; concurrent assertions compare each output group
// against a reference record kept one cycle behind the inputs.

`timescale 1ns/1ps

module tb_exec_stage;

    `include "tb_exec_ref.svh"

    logic        CLK, RST, stall, flush;
    logic [31:0] d_pc, d_imm, d_rs1_val, d_rs2_val, fwd_m_rd_val, fwd_w_rd_val;
    logic        d_valid, fwd_m_valid, fwd_w_valid;
    logic [6:0]  d_opcode, d_funct7;
    logic [2:0]  d_funct3;
    logic [4:0]  d_rd, d_rs1, d_rs2, fwd_m_rd, fwd_w_rd;
    logic [31:0] a_pc, a_new_pc, a_rd_val, a_load_addr, a_store_addr, a_store_data;
    logic        a_valid, a_do_jmp, a_load_rden, a_load_signed, a_store_wren;
    logic [4:0]  a_rd;
    logic [1:0]  a_load_size;
    logic [3:0]  a_store_strb;

    // latch model and expected record
    logic        l_valid;
    logic [31:0] l_pc, l_imm, l_rs1v, l_rs2v, op_a, op_b;
    logic [6:0]  l_opc, l_f7;
    logic [2:0]  l_f3;
    logic [4:0]  l_rd, l_rs1, l_rs2;
    logic [70:0] exp_ctrl;
    logic [31:0] exp_res;
    logic [35:0] exp_load;
    logic [68:0] exp_store;
    logic        chk_en = 1'b0;
    string       tname = "reset";

    exec_stage UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic mismatch(input string what, input logic [127:0] exp, act);
        $display("CHECK FAILED %s %s: expected %h actual %h", tname, what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "output mismatch");
    endtask

    // ----------------------------------------
    // checks, sampled at the rising edge
    // ----------------------------------------
    a_ctrl: assert property (@(posedge CLK) !chk_en ||
        exp_ctrl == {a_valid, a_do_jmp, a_new_pc, a_pc, a_rd})
        else mismatch("ctrl", 128'(exp_ctrl), 128'({a_valid, a_do_jmp, a_new_pc, a_pc, a_rd}));
    a_res: assert property (@(posedge CLK) !chk_en || exp_res == a_rd_val)
        else mismatch("rd_val", 128'(exp_res), 128'(a_rd_val));
    a_load: assert property (@(posedge CLK) !chk_en ||
        exp_load == {a_load_rden, a_load_addr, a_load_size, a_load_signed})
        else mismatch("load", 128'(exp_load),
                      128'({a_load_rden, a_load_addr, a_load_size, a_load_signed}));
    a_store: assert property (@(posedge CLK) !chk_en ||
        exp_store == {a_store_wren, a_store_addr, a_store_strb, a_store_data})
        else mismatch("store", 128'(exp_store),
                      128'({a_store_wren, a_store_addr, a_store_strb, a_store_data}));
    a_excl: assert property (@(posedge CLK) !chk_en || !(a_load_rden && a_store_wren))
        else mismatch("excl", 128'd0, 128'({a_load_rden, a_store_wren}));

    // one clock: update latch model from what was sampled, then drive again
    task automatic step(input logic rst_v, input logic rnd);
        logic [31:0] r;
        @(posedge CLK);
        #2;
        if (RST || (flush && !stall)) begin
            {l_valid, l_pc, l_opc, l_f3, l_f7, l_imm, l_rd} = '0;
            {l_rs1, l_rs1v, l_rs2, l_rs2v} = '0;
        end else if (!stall) begin
            {l_valid, l_pc, l_opc, l_f3, l_f7, l_imm} =
                {d_valid, d_pc, d_opcode, d_funct3, d_funct7, d_imm};
            {l_rd, l_rs1, l_rs1v, l_rs2, l_rs2v} = {d_rd, d_rs1, d_rs1_val, d_rs2, d_rs2_val};
        end
        RST = rst_v;
        if (rnd) begin
            r = rand32();
            stall = r[2:0] == 3'd0;
            flush = r[5:3] == 3'd0;
            d_valid = r[6] | r[7];
            d_rd = r[12:8];
            d_rs1 = {3'b0, r[14:13]};                  // small indices hit forwards
            d_rs2 = {3'b0, r[16:15]};
            fwd_m_valid = r[17];
            fwd_m_rd = {3'b0, r[19:18]};
            fwd_w_valid = r[20];
            fwd_w_rd = {3'b0, r[22:21]};
            d_funct3 = r[25:23];
            d_funct7 = exec_pkg::F7_BASE;
            case (r[31:26] % 9)
                0: d_opcode = exec_pkg::OP_REG;
                1: d_opcode = exec_pkg::OP_IMM;
                2: d_opcode = exec_pkg::OP_LUI;
                3: d_opcode = exec_pkg::OP_AUIPC;
                4: d_opcode = exec_pkg::OP_JAL;
                5: d_opcode = exec_pkg::OP_JALR;
                6: d_opcode = exec_pkg::OP_BRANCH;
                7: d_opcode = exec_pkg::OP_LOAD;
                default: d_opcode = exec_pkg::OP_STORE;
            endcase
            r = rand32();
            if (d_funct3 == 3'd5 || (d_funct3 == 3'd0 && d_opcode == exec_pkg::OP_REG))
                d_funct7 = r[0] ? exec_pkg::F7_ALT : exec_pkg::F7_BASE;
            if (d_opcode == exec_pkg::OP_JALR)
                d_funct3 = 3'd0;
            if (d_opcode == exec_pkg::OP_BRANCH && d_funct3[2:1] == 2'b01)
                d_funct3 = {1'b1, r[2:1]};             // skip the two unused codes
            if (d_opcode == exec_pkg::OP_LOAD && (d_funct3 == 3'd3 || d_funct3 > 3'd5))
                d_funct3 = {1'b0, r[2], 1'b0};
            if (d_opcode == exec_pkg::OP_STORE && d_funct3 > 3'd2)
                d_funct3 = {1'b0, r[2:1] == 2'd3 ? 2'd2 : r[2:1]};
            d_pc = rand32() & 32'hffff_fffc;
            d_imm = rand32();
            d_rs1_val = rand32();
            d_rs2_val = r[5:4] == 2'd0 ? d_rs1_val : rand32();   // equal operands too
            fwd_m_rd_val = rand32();
            fwd_w_rd_val = rand32();
        end
        op_a = forwarded_operand(l_rs1, l_rs1v, fwd_m_valid, fwd_m_rd, fwd_m_rd_val,
                                 fwd_w_valid, fwd_w_rd, fwd_w_rd_val);
        op_b = forwarded_operand(l_rs2, l_rs2v, fwd_m_valid, fwd_m_rd, fwd_m_rd_val,
                                 fwd_w_valid, fwd_w_rd, fwd_w_rd_val);
        exp_ctrl = {l_valid, jump_outcome(l_opc, l_f3, l_pc, l_imm, op_a, op_b), l_pc, l_rd};
        exp_res = dest_value(l_opc, l_f3, l_f7, l_pc, l_imm, op_a, op_b);
        exp_load = load_request(l_opc, l_f3, op_a, l_imm);
        exp_store = store_request(l_opc, l_f3, op_a, op_b, l_imm);
        chk_en = 1'b1;
    endtask

    // run limit
    initial begin
        repeat (2000) @(posedge CLK);
        $display("timeout: stimulus did not complete within the cycle limit");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        {RST, stall, flush, d_valid, fwd_m_valid, fwd_w_valid} = 6'b100000;
        {d_pc, d_imm, d_rs1_val, d_rs2_val, fwd_m_rd_val, fwd_w_rd_val} = '0;
        {d_opcode, d_funct7, d_funct3} = '0;
        {d_rd, d_rs1, d_rs2, fwd_m_rd, fwd_w_rd} = '0;
        repeat (4) step(1'b1, 1'b0);
        step(1'b0, 1'b0);                                  // outputs idle after reset
        tname = "random stream";
        repeat (1200) step(1'b0, 1'b1);
        step(1'b0, 1'b0);
        @(posedge CLK);
        #1;                                                // let the last checks report
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- flist.f
exec_pkg.sv
exec_operand_if.sv
exec_issue_reg.sv
exec_int_alu.sv
exec_branch_unit.sv
exec_mem_req.sv
exec_stage.sv
+incdir+.
tb_exec_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
RTL_TOP   ?= exec_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
